/* list.f */
color_pkg.sv
freq_counter.sv
percent_divider.sv
reference_table.sv
color_matcher.sv
consistency_filter.sv
color_sequencer.sv
washer_sorter_top.sv
washer_sorter_tb.sv

/* Bender.yml */
package:
  name: washer_sorter

sources:
  - color_pkg.sv
  - freq_counter.sv
  - percent_divider.sv
  - reference_table.sv
  - color_matcher.sv
  - consistency_filter.sv
  - color_sequencer.sv
  - washer_sorter_top.sv
  - target: test
    files:
      - washer_sorter_tb.sv

/* washer_sorter_tb.sv */
`timescale 1ns/1ps

module washer_sorter_tb;

    localparam int GATE       = 2048;
    localparam int MATCHES    = 4;
    localparam int CLEAR_HALF = 8;  // Clear half-period in clocks
    localparam int NUM_ROWS   = 12;
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS) * 14 * 4 * GATE * 10 * 2;

    typedef struct packed {
        logic [8:0]         red;
        logic [8:0]         green;
        logic [8:0]         blue;
        logic               cal;
        color_pkg::washer_t cal_washer;
        logic               steady;    // Expected detection follows this row
        logic [7:0]         readings;
    } stim_row_t;

    logic                    CLK100MHZ;
    logic                    reset;
    logic                    sensor;
    color_pkg::cal_req_t     cal;
    color_pkg::filter_pins_t filter_pins;
    color_pkg::washer_t      detected;
    logic [3:0]              leds;

    stim_row_t          stim [NUM_ROWS];
    string              stim_name [NUM_ROWS];
    int                 model_ref [1:4][3]; // Indexed by washer code
    int                 cur_red, cur_green, cur_blue;
    int                 half_len, half_cnt;
    int                 readings_done;
    color_pkg::filter_pins_t pins_prev;
    color_pkg::washer_t expected;
    int                 errors, checks, row_errors;

    washer_sorter_top #(
        .GATE_CYCLES (GATE),
        .MATCH_COUNT (MATCHES)
    ) DUT (
        .CLK100MHZ   (CLK100MHZ),
        .reset       (reset),
        .sensor      (sensor),
        .cal         (cal),
        .filter_pins (filter_pins),
        .detected    (detected),
        .leds        (leds)
    );

    initial
    begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    ////////////////////////////////////////////////////////////
    // Sensor model and reading counter
    ////////////////////////////////////////////////////////////

    function automatic int half_period(color_pkg::filter_pins_t pins);
        if (pins == color_pkg::PINS_RED)
            return CLEAR_HALF * 100 / cur_red;
        else if (pins == color_pkg::PINS_GREEN)
            return CLEAR_HALF * 100 / cur_green;
        else if (pins == color_pkg::PINS_BLUE)
            return CLEAR_HALF * 100 / cur_blue;
        return CLEAR_HALF;
    endfunction

    // Filter order clear, red, green, blue
    function automatic color_pkg::filter_pins_t next_pins(color_pkg::filter_pins_t pins);
        if (pins == color_pkg::PINS_CLEAR)
            return color_pkg::PINS_RED;
        else if (pins == color_pkg::PINS_RED)
            return color_pkg::PINS_GREEN;
        else if (pins == color_pkg::PINS_GREEN)
            return color_pkg::PINS_BLUE;
        return color_pkg::PINS_CLEAR;
    endfunction

    always @(posedge CLK100MHZ)
    begin
        half_len = half_period(filter_pins); // Sampled at the edge
        #1;
        if (half_cnt + 1 >= half_len)
        begin
            sensor   = ~sensor;
            half_cnt = 0;
        end
        else
            half_cnt = half_cnt + 1;
    end

    // A return to clear marks the start of a new reading
    always @(posedge CLK100MHZ)
    begin
        pins_prev <= filter_pins;
        if (!reset && filter_pins != pins_prev)
        begin
            checks = checks + 1;
            assert (filter_pins == next_pins(pins_prev))
            else
            begin
                $display("FAILED at %0t ns: filter_pins = %b, expected %b",
                         $time, filter_pins, next_pins(pins_prev));
                errors = errors + 1;
            end
        end
        if (!reset && filter_pins == color_pkg::PINS_CLEAR
                   && pins_prev != color_pkg::PINS_CLEAR)
            readings_done <= readings_done + 1;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped producing readings",
                 WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    function automatic int abs_int(int x);
        return (x < 0) ? -x : x;
    endfunction

    // Strictly nearest reference, NONE on a tie
    function automatic color_pkg::washer_t nearest(int r, int g, int b);
        int d [1:4];
        color_pkg::washer_t w;
        int best;
        best = 0;
        for (int i = 1; i <= 4; i++)
            d[i] = abs_int(r - model_ref[i][0]) + abs_int(g - model_ref[i][1])
                 + abs_int(b - model_ref[i][2]);
        for (int i = 1; i <= 4; i++)
            if (best == 0 || d[i] < d[best])
                best = i;
        for (int i = 1; i <= 4; i++)
            if (i != best && d[i] == d[best])
                return color_pkg::NONE;
        w = color_pkg::washer_t'(best);
        return w;
    endfunction

    function automatic logic [3:0] led_pattern(color_pkg::washer_t w);
        case (w)
            color_pkg::RED_WASHER:    return 4'b0001;
            color_pkg::BLUE_WASHER:   return 4'b0010;
            color_pkg::GREEN_WASHER:  return 4'b0100;
            color_pkg::YELLOW_WASHER: return 4'b1000;
            default:                  return 4'b0000;
        endcase
    endfunction

    task automatic check_outputs(color_pkg::washer_t want);
        checks = checks + 2;
        assert (detected == want)
        else
        begin
            $display("FAILED at %0t ns: detected = %s (%0d), expected %s (%0d)",
                     $time, detected.name(), detected, want.name(), want);
            errors = errors + 1;
        end
        assert (leds == led_pattern(want))
        else
        begin
            $display("FAILED at %0t ns: leds = %b, expected %b",
                     $time, leds, led_pattern(want));
            errors = errors + 1;
        end
    endtask

    task automatic wait_readings(int n);
        int target;
        target = readings_done + n;
        while (readings_done < target)
        begin
            @(posedge CLK100MHZ);
            #1;
        end
        repeat (4) @(posedge CLK100MHZ); // Matcher and filter latency
        #1;
    endtask

    task automatic set_row(int i, string name, int r, int g, int b, logic c,
                           color_pkg::washer_t w, logic steady, int n);
        stim[i]      = '{red: 9'(r), green: 9'(g), blue: 9'(b), cal: c,
                         cal_washer: w, steady: steady, readings: 8'(n)};
        stim_name[i] = name;
    endtask

    task automatic build_stimulus();
        model_ref[1] = '{34, 26, 37};
        model_ref[2] = '{25, 29, 44};
        model_ref[3] = '{29, 28, 39};
        model_ref[4] = '{33, 30, 29};
        set_row(0,  "red reference",    34, 26, 37, 0, color_pkg::NONE, 1, 12);
        set_row(1,  "blue reference",   25, 29, 44, 0, color_pkg::NONE, 1, 12);
        set_row(2,  "green reference",  29, 28, 39, 0, color_pkg::NONE, 1, 12);
        set_row(3,  "yellow reference", 33, 30, 29, 0, color_pkg::NONE, 1, 12);
        set_row(4,  "yellow held",      33, 30, 29, 0, color_pkg::NONE, 1, 6);
        for (int i = 5; i < 11; i += 2)
        begin
            set_row(i,     "alternate red",  34, 26, 37, 0, color_pkg::NONE, 0, 1);
            set_row(i + 1, "alternate blue", 25, 29, 44, 0, color_pkg::NONE, 0, 1);
        end
        set_row(11, "calibrate yellow", 42, 22, 36, 1, color_pkg::YELLOW_WASHER, 1, 12);
    endtask

    initial
    begin
        reset         = 1'b1;
        sensor        = 1'b0;
        cal           = '{req: 1'b0, washer: color_pkg::NONE};
        half_cnt      = 0;
        readings_done = 0;
        errors        = 0;
        checks        = 0;
        expected      = color_pkg::NONE;
        build_stimulus();
        cur_red   = stim[0].red;
        cur_green = stim[0].green;
        cur_blue  = stim[0].blue;
        repeat (5) @(posedge CLK100MHZ);
        #1 reset = 1'b0;

        repeat (4) @(posedge CLK100MHZ);
        #1;
        row_errors = errors;
        check_outputs(color_pkg::NONE);
        $display("Test reset state: %s", (errors == row_errors) ? "ok" : "mismatch");

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            row_errors = errors;
            cur_red    = stim[i].red;
            cur_green  = stim[i].green;
            cur_blue   = stim[i].blue;
            if (stim[i].cal)
            begin
                cal = '{req: 1'b1, washer: stim[i].cal_washer};
                @(posedge CLK100MHZ);
                #1 cal = '{req: 1'b0, washer: color_pkg::NONE};
                model_ref[stim[i].cal_washer] = '{cur_red, cur_green, cur_blue};
            end
            if (stim[i].steady)
                expected = nearest(cur_red, cur_green, cur_blue);
            wait_readings(stim[i].readings);
            check_outputs(expected);
            $display("Test row %0d %s: %s", i, stim_name[i],
                     (errors == row_errors) ? "ok" : "mismatch");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* washer_sorter_top.sv */
`timescale 1ns/1ps

module washer_sorter_top #(
    parameter int GATE_CYCLES = 100000,
    parameter int MATCH_COUNT = 4
) (
    input  logic                     CLK100MHZ,
    input  logic                     reset,
    input  logic                     sensor,
    input  color_pkg::cal_req_t      cal,
    output color_pkg::filter_pins_t  filter_pins,
    output color_pkg::washer_t       detected,
    output logic [3:0]               leds
);

    logic                    freq_start, freq_done;
    color_pkg::freq_t        frequency;
    logic                    div_start, div_done;
    color_pkg::percent_t     percent;
    color_pkg::freq_t        dividend, divisor;
    logic                    result_valid, write;
    color_pkg::rgb_percent_t reading;
    color_pkg::washer_t      write_washer;
    color_pkg::rgb_percent_t red_ref, blue_ref, green_ref, yellow_ref;
    logic                    class_valid;
    color_pkg::washer_t      washer;

    ////////////////////////////////////////////////////////////
    // Control and datapath
    ////////////////////////////////////////////////////////////

    color_sequencer u_sequencer (
        .CLK100MHZ    (CLK100MHZ),
        .reset        (reset),
        .cal          (cal),
        .filter_pins  (filter_pins),
        .freq_start   (freq_start),
        .freq_done    (freq_done),
        .frequency    (frequency),
        .div_start    (div_start),
        .div_done     (div_done),
        .percent      (percent),
        .dividend     (dividend),
        .divisor      (divisor),
        .result_valid (result_valid),
        .reading      (reading),
        .write        (write),
        .write_washer (write_washer)
    );

    freq_counter #(
        .GATE_CYCLES (GATE_CYCLES)
    ) u_freq_counter (
        .CLK100MHZ (CLK100MHZ),
        .reset     (reset),
        .sensor    (sensor),
        .start     (freq_start),
        .done      (freq_done),
        .frequency (frequency)
    );

    percent_divider u_divider (
        .CLK100MHZ (CLK100MHZ),
        .reset     (reset),
        .start     (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .done      (div_done),
        .percent   (percent)
    );

    ////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////

    reference_table u_references (
        .CLK100MHZ    (CLK100MHZ),
        .reset        (reset),
        .write        (write),
        .write_washer (write_washer),
        .write_value  (reading),
        .red_ref      (red_ref),
        .blue_ref     (blue_ref),
        .green_ref    (green_ref),
        .yellow_ref   (yellow_ref)
    );

    color_matcher u_matcher (
        .CLK100MHZ    (CLK100MHZ),
        .reset        (reset),
        .result_valid (result_valid),
        .reading      (reading),
        .red_ref      (red_ref),
        .blue_ref     (blue_ref),
        .green_ref    (green_ref),
        .yellow_ref   (yellow_ref),
        .class_valid  (class_valid),
        .washer       (washer)
    );

    consistency_filter #(
        .MATCH_COUNT (MATCH_COUNT)
    ) u_filter (
        .CLK100MHZ   (CLK100MHZ),
        .reset       (reset),
        .class_valid (class_valid),
        .washer      (washer),
        .detected    (detected),
        .leds        (leds)
    );

endmodule

/* color_sequencer.sv */
`timescale 1ns/1ps

module color_sequencer (
    input  logic                     CLK100MHZ,
    input  logic                     reset,
    input  color_pkg::cal_req_t      cal,
    output color_pkg::filter_pins_t  filter_pins,
    output logic                     freq_start,
    input  logic                     freq_done,
    input  color_pkg::freq_t         frequency,
    output logic                     div_start,
    input  logic                     div_done,
    input  color_pkg::percent_t      percent,
    output color_pkg::freq_t         dividend,
    output color_pkg::freq_t         divisor,
    output logic                     result_valid,
    output color_pkg::rgb_percent_t  reading,
    output logic                     write,
    output color_pkg::washer_t       write_washer
);

    color_pkg::seq_state_t state;
    color_pkg::filter_t    filter;
    logic                  launch; // First clock in a state
    logic                  pending;
    color_pkg::washer_t    pending_washer;
    logic                  cal_active;

    always_comb
    begin
        case (filter)
            color_pkg::FILTER_RED:   filter_pins = color_pkg::PINS_RED;
            color_pkg::FILTER_GREEN: filter_pins = color_pkg::PINS_GREEN;
            color_pkg::FILTER_BLUE:  filter_pins = color_pkg::PINS_BLUE;
            default:                 filter_pins = color_pkg::PINS_CLEAR;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Reading sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            state          <= color_pkg::CLEAR_COUNT;
            filter         <= color_pkg::FILTER_CLEAR;
            launch         <= 1'b1;
            pending        <= 1'b0;
            pending_washer <= color_pkg::NONE;
            cal_active     <= 1'b0;
            freq_start     <= 1'b0;
            div_start      <= 1'b0;
            result_valid   <= 1'b0;
            write          <= 1'b0;
        end
        else
        begin
            launch       <= 1'b0;
            freq_start   <= 1'b0;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            write        <= 1'b0;
            case (state)
                color_pkg::CLEAR_COUNT:
                begin
                    if (launch)
                    begin
                        freq_start   <= 1'b1;
                        cal_active   <= pending; // Request taken per reading
                        write_washer <= pending_washer;
                        pending      <= 1'b0;
                    end
                    else if (freq_done)
                    begin
                        divisor <= frequency; // Clear count
                        filter  <= color_pkg::FILTER_RED;
                        state   <= color_pkg::RED_COUNT;
                        launch  <= 1'b1;
                    end
                end
                color_pkg::RED_COUNT, color_pkg::GREEN_COUNT, color_pkg::BLUE_COUNT:
                begin
                    if (launch)
                        freq_start <= 1'b1;
                    else if (freq_done)
                    begin
                        dividend <= frequency;
                        launch   <= 1'b1;
                        case (state)
                            color_pkg::RED_COUNT:   state <= color_pkg::RED_DIVIDE;
                            color_pkg::GREEN_COUNT: state <= color_pkg::GREEN_DIVIDE;
                            default:                state <= color_pkg::BLUE_DIVIDE;
                        endcase
                    end
                end
                color_pkg::RED_DIVIDE:
                begin
                    if (launch)
                        div_start <= 1'b1;
                    else if (div_done)
                    begin
                        reading.red <= percent;
                        filter      <= color_pkg::FILTER_GREEN;
                        state       <= color_pkg::GREEN_COUNT;
                        launch      <= 1'b1;
                    end
                end
                color_pkg::GREEN_DIVIDE:
                begin
                    if (launch)
                        div_start <= 1'b1;
                    else if (div_done)
                    begin
                        reading.green <= percent;
                        filter        <= color_pkg::FILTER_BLUE;
                        state         <= color_pkg::BLUE_COUNT;
                        launch        <= 1'b1;
                    end
                end
                color_pkg::BLUE_DIVIDE:
                begin
                    if (launch)
                        div_start <= 1'b1;
                    else if (div_done)
                    begin
                        reading.blue <= percent;
                        state        <= color_pkg::FINISH;
                    end
                end
                color_pkg::FINISH:
                begin
                    if (cal_active)
                        write <= 1'b1; // Reading becomes a reference
                    else
                        result_valid <= 1'b1;
                    filter <= color_pkg::FILTER_CLEAR;
                    state  <= color_pkg::CLEAR_COUNT;
                    launch <= 1'b1;
                end
            endcase

            // Latest request wins
            if (cal.req)
            begin
                pending        <= 1'b1;
                pending_washer <= cal.washer;
            end
        end
    end

endmodule

/* consistency_filter.sv */
`timescale 1ns/1ps

module consistency_filter #(
    parameter int MATCH_COUNT = 4
) (
    input  logic                CLK100MHZ,
    input  logic                reset,
    input  logic                class_valid,
    input  color_pkg::washer_t  washer,
    output color_pkg::washer_t  detected,
    output logic [3:0]          leds
);

    localparam int CNT_W = $clog2(MATCH_COUNT + 1);

    color_pkg::washer_t prev_class;
    logic [CNT_W-1:0]   match_cnt;

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            prev_class <= color_pkg::NONE;
            match_cnt  <= '0;
            detected   <= color_pkg::NONE;
        end
        else if (class_valid)
        begin
            if (prev_class == color_pkg::NONE)
                prev_class <= washer; // First class only primes
            else if (washer == prev_class)
            begin
                if (match_cnt + 1'b1 == CNT_W'(MATCH_COUNT))
                begin
                    detected  <= washer;
                    match_cnt <= '0;
                end
                else
                    match_cnt <= match_cnt + 1'b1;
            end
            else
            begin
                prev_class <= washer;
                match_cnt  <= '0;
            end
        end
    end

    always_comb
    begin
        case (detected)
            color_pkg::RED_WASHER:    leds = 4'b0001;
            color_pkg::BLUE_WASHER:   leds = 4'b0010;
            color_pkg::GREEN_WASHER:  leds = 4'b0100;
            color_pkg::YELLOW_WASHER: leds = 4'b1000;
            default:                  leds = 4'b0000;
        endcase
    end

endmodule

/* color_matcher.sv */
`timescale 1ns/1ps

module color_matcher (
    input  logic                     CLK100MHZ,
    input  logic                     reset,
    input  logic                     result_valid,
    input  color_pkg::rgb_percent_t  reading,
    input  color_pkg::rgb_percent_t  red_ref,
    input  color_pkg::rgb_percent_t  blue_ref,
    input  color_pkg::rgb_percent_t  green_ref,
    input  color_pkg::rgb_percent_t  yellow_ref,
    output logic                     class_valid,
    output color_pkg::washer_t       washer
);

    function automatic color_pkg::dist_t abs_diff(color_pkg::percent_t a,
                                                  color_pkg::percent_t b);
        return (a > b) ? color_pkg::dist_t'(a - b) : color_pkg::dist_t'(b - a);
    endfunction

    // Sum of absolute differences over red, green, blue
    function automatic color_pkg::dist_t distance(color_pkg::rgb_percent_t x,
                                                  color_pkg::rgb_percent_t y);
        return abs_diff(x.red, y.red) + abs_diff(x.green, y.green)
             + abs_diff(x.blue, y.blue);
    endfunction

    color_pkg::dist_t   d_red, d_blue, d_green, d_yellow;
    color_pkg::washer_t best;

    always_comb
    begin
        d_red    = distance(reading, red_ref);
        d_blue   = distance(reading, blue_ref);
        d_green  = distance(reading, green_ref);
        d_yellow = distance(reading, yellow_ref);
        best     = color_pkg::NONE; // Tie, no strict winner
        if (d_red < d_blue && d_red < d_green && d_red < d_yellow)
            best = color_pkg::RED_WASHER;
        else if (d_blue < d_red && d_blue < d_green && d_blue < d_yellow)
            best = color_pkg::BLUE_WASHER;
        else if (d_green < d_red && d_green < d_blue && d_green < d_yellow)
            best = color_pkg::GREEN_WASHER;
        else if (d_yellow < d_red && d_yellow < d_blue && d_yellow < d_green)
            best = color_pkg::YELLOW_WASHER;
    end

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            class_valid <= 1'b0;
            washer      <= color_pkg::NONE;
        end
        else
        begin
            class_valid <= result_valid;
            if (result_valid && best != color_pkg::NONE)
                washer <= best;
        end
    end

endmodule

/* reference_table.sv */
`timescale 1ns/1ps

module reference_table (
    input  logic                     CLK100MHZ,
    input  logic                     reset,
    input  logic                     write,
    input  color_pkg::washer_t       write_washer,
    input  color_pkg::rgb_percent_t  write_value,
    output color_pkg::rgb_percent_t  red_ref,
    output color_pkg::rgb_percent_t  blue_ref,
    output color_pkg::rgb_percent_t  green_ref,
    output color_pkg::rgb_percent_t  yellow_ref
);

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            red_ref    <= color_pkg::RED_DEFAULT;
            blue_ref   <= color_pkg::BLUE_DEFAULT;
            green_ref  <= color_pkg::GREEN_DEFAULT;
            yellow_ref <= color_pkg::YELLOW_DEFAULT;
        end
        else if (write)
        begin
            case (write_washer)
                color_pkg::RED_WASHER:    red_ref    <= write_value;
                color_pkg::BLUE_WASHER:   blue_ref   <= write_value;
                color_pkg::GREEN_WASHER:  green_ref  <= write_value;
                color_pkg::YELLOW_WASHER: yellow_ref <= write_value;
                default:                  ; // NONE leaves the table alone
            endcase
        end
    end

endmodule

/* percent_divider.sv */
`timescale 1ns/1ps

module percent_divider (
    input  logic                  CLK100MHZ,
    input  logic                  reset,
    input  logic                  start,
    input  color_pkg::freq_t      dividend,
    input  color_pkg::freq_t      divisor,
    output logic                  done,
    output color_pkg::percent_t   percent
);

    localparam int NUM_W = color_pkg::FREQ_W + 7; // Room for times 100
    localparam int CNT_W = $clog2(NUM_W);

    logic [NUM_W-1:0]             num_q;
    logic [NUM_W-1:0]             quot_q;
    logic [NUM_W-1:0]             quot_next;
    color_pkg::freq_t             rem_q;
    color_pkg::freq_t             div_q;
    logic [color_pkg::FREQ_W:0]   rem_shift;
    logic [color_pkg::FREQ_W:0]   rem_sub;
    logic                         quot_bit;
    logic [CNT_W-1:0]             bit_cnt;
    logic                         busy;

    // One restoring step per clock
    always_comb
    begin
        rem_shift = {rem_q, num_q[NUM_W-1]};
        rem_sub   = rem_shift - {1'b0, div_q};
        quot_bit  = (rem_shift >= {1'b0, div_q});
        quot_next = {quot_q[NUM_W-2:0], quot_bit};
    end

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                if (divisor == '0)
                begin
                    percent <= '0; // No light, no ratio
                    done    <= 1'b1;
                end
                else
                begin
                    num_q   <= {7'd0, dividend} * NUM_W'(100);
                    div_q   <= divisor;
                    rem_q   <= '0;
                    quot_q  <= '0;
                    bit_cnt <= CNT_W'(NUM_W - 1);
                    busy    <= 1'b1;
                end
            end
            else if (busy)
            begin
                num_q  <= num_q << 1;
                quot_q <= quot_next;
                rem_q  <= quot_bit ? rem_sub[color_pkg::FREQ_W-1:0]
                                   : rem_shift[color_pkg::FREQ_W-1:0];
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == '0)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    if (|quot_next[NUM_W-1:color_pkg::PERCENT_W])
                        percent <= '1; // Saturate
                    else
                        percent <= quot_next[color_pkg::PERCENT_W-1:0];
                end
            end
        end
    end

endmodule

/* freq_counter.sv */
`timescale 1ns/1ps

module freq_counter #(
    parameter int GATE_CYCLES = 100000
) (
    input  logic                CLK100MHZ,
    input  logic                reset,
    input  logic                sensor,
    input  logic                start,
    output logic                done,
    output color_pkg::freq_t    frequency
);

    localparam int GATE_W = $clog2(GATE_CYCLES + 1);

    logic [1:0]        sync_q;
    logic              sensor_prev;
    logic              rise;
    logic              active;
    logic [GATE_W-1:0] gate_cnt;

    assign rise = sync_q[1] & ~sensor_prev;

    always_ff @(posedge CLK100MHZ)
    begin
        if (reset)
        begin
            sync_q      <= '0;
            sensor_prev <= 1'b0;
            active      <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            sync_q      <= {sync_q[0], sensor}; // Two-flop synchroniser
            sensor_prev <= sync_q[1];
            done        <= 1'b0;
            if (start)
            begin
                active    <= 1'b1;
                gate_cnt  <= '0;
                frequency <= '0;
            end
            else if (active)
            begin
                if (rise)
                    frequency <= frequency + 1'b1;
                gate_cnt <= gate_cnt + 1'b1;
                if (gate_cnt == GATE_W'(GATE_CYCLES - 1)) // Window over
                begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

endmodule

/* color_pkg.sv */
package color_pkg;

    localparam int FREQ_W    = 21;
    localparam int PERCENT_W = 9;
    localparam int DIST_W    = 11;

    typedef logic [FREQ_W-1:0]    freq_t;
    typedef logic [PERCENT_W-1:0] percent_t;
    typedef logic [DIST_W-1:0]    dist_t;

    typedef enum logic [2:0] {
        NONE,
        RED_WASHER,
        BLUE_WASHER,
        GREEN_WASHER,
        YELLOW_WASHER
    } washer_t;

    typedef enum logic [1:0] {
        FILTER_CLEAR,
        FILTER_RED,
        FILTER_GREEN,
        FILTER_BLUE
    } filter_t;

    typedef struct packed {
        logic s2;
        logic s3;
    } filter_pins_t;

    // Sensor select codes, s2 then s3
    localparam filter_pins_t PINS_RED   = '{s2: 1'b0, s3: 1'b0};
    localparam filter_pins_t PINS_BLUE  = '{s2: 1'b0, s3: 1'b1};
    localparam filter_pins_t PINS_CLEAR = '{s2: 1'b1, s3: 1'b0};
    localparam filter_pins_t PINS_GREEN = '{s2: 1'b1, s3: 1'b1};

    typedef struct packed {
        percent_t red;
        percent_t green;
        percent_t blue;
    } rgb_percent_t;

    typedef struct packed {
        logic    req;
        washer_t washer;
    } cal_req_t;

    typedef enum logic [2:0] {
        CLEAR_COUNT,
        RED_COUNT,
        RED_DIVIDE,
        GREEN_COUNT,
        GREEN_DIVIDE,
        BLUE_COUNT,
        BLUE_DIVIDE,
        FINISH
    } seq_state_t;

    // Factory references, percent of clear
    localparam rgb_percent_t RED_DEFAULT    = '{red: 9'd34, green: 9'd26, blue: 9'd37};
    localparam rgb_percent_t BLUE_DEFAULT   = '{red: 9'd25, green: 9'd29, blue: 9'd44};
    localparam rgb_percent_t GREEN_DEFAULT  = '{red: 9'd29, green: 9'd28, blue: 9'd39};
    localparam rgb_percent_t YELLOW_DEFAULT = '{red: 9'd33, green: 9'd30, blue: 9'd29};

endpackage
